// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

  // #########################################################################
  // Geometry
  // #########################################################################

  localparam int unsigned xlen = 32;

  localparam int unsigned line_words_log2 = 1; // Two words per line.
  localparam int unsigned sets_log2 = 4;       // Sixteen lines.

  localparam int unsigned line_words = 1 << line_words_log2;
  localparam int unsigned sets = 1 << sets_log2;

  // Field widths of a fetch address, from the top: tag, index, offset, byte.
  localparam int unsigned offset_w = line_words_log2;
  localparam int unsigned index_w = sets_log2;
  localparam int unsigned tag_w = xlen - index_w - offset_w - 2;

  // #########################################################################
  // Sequencer and queue
  // #########################################################################

  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  localparam int unsigned queue_depth = 4;
  localparam int unsigned queue_ptr_w = 2;

  // #########################################################################
  // Refill sequence
  // #########################################################################

  // One address/response pair per word of the line, then a write-back cycle.
  typedef enum logic [2:0] {
    idle       = 3'd0,
    req_0      = 3'd1,
    resp_0     = 3'd2,
    req_1      = 3'd3,
    resp_1     = 3'd4,
    write_back = 3'd5
  } l1i_state_e;

endpackage

// ==== hw/fetch_pc.sv ====
module fetch_pc (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      redirect_valid,
  input  logic [fetch_pkg::xlen-1:0] redirect_pc,
  input  logic                      hit_valid,
  input  logic                      queue_ready,
  output logic [fetch_pkg::xlen-1:0] fetch_pc
);

  import fetch_pkg::*;

  logic            advance;
  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] pc_next;

  // The hit word is pushed into the queue in this same cycle.
  assign advance = hit_valid && queue_ready;

  always_comb begin
    pc_next = pc_q;
    if (redirect_valid) begin
      pc_next = redirect_pc; // A redirect wins over the sequential step.
    end else if (advance) begin
      pc_next = pc_q + xlen'(4);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q <= reset_pc;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign fetch_pc = pc_q;

  // #########################################################################
  // Checks
  // #########################################################################

  // Every fetch address must be word aligned.
  assert property (@(posedge clock) disable iff (reset)
    fetch_pc[1:0] == 2'b00);

endmodule

// ==== hw/fetch_l1i.sv ====
module fetch_l1i (
  input  logic                      clock,
  input  logic                      reset,
  input  logic [fetch_pkg::xlen-1:0] fetch_pc,
  input  logic                      redirect_valid,
  input  logic                      fence,
  output logic                      hit_valid,
  output logic [fetch_pkg::xlen-1:0] hit_inst,
  output logic                      mem_arvalid,
  output logic [fetch_pkg::xlen-1:0] mem_araddr,
  input  logic                      mem_arready,
  input  logic                      mem_rvalid,
  input  logic [fetch_pkg::xlen-1:0] mem_rdata,
  output logic                      mem_rready
);

  import fetch_pkg::*;

  // #########################################################################
  // Storage
  // #########################################################################

  logic [xlen-1:0]  data_mem [sets][line_words];
  logic [tag_w-1:0] tag_mem  [sets];
  logic [sets-1:0]  line_valid;

  l1i_state_e state;

  logic pend_redirect; // Redirect seen while a refill was running.
  logic pend_fence;    // Fence seen while a refill was running.

  // Line address (tag and index) of the refill in progress.
  logic [tag_w+index_w-1:0] line_addr;

  logic [tag_w-1:0]    pc_tag;
  logic [index_w-1:0]  pc_index;
  logic [offset_w-1:0] pc_offset;

  logic [tag_w-1:0]    line_tag;
  logic [index_w-1:0]  line_index;
  logic [offset_w-1:0] req_offset;

  logic lookup_hit;
  logic miss;
  logic refill_busy;

  // #########################################################################
  // Lookup
  // #########################################################################

  assign pc_tag    = fetch_pc[xlen-1 -: tag_w];
  assign pc_index  = fetch_pc[offset_w+2 +: index_w];
  assign pc_offset = fetch_pc[2 +: offset_w];

  assign lookup_hit = line_valid[pc_index] && (tag_mem[pc_index] == pc_tag);

  // Hits are only reported from idle with nothing left over from a refill.
  assign hit_valid = (state == idle) && lookup_hit && !pend_redirect && !pend_fence;
  assign hit_inst  = data_mem[pc_index][pc_offset];

  // A redirect cycle carries a stale PC, so it never starts a refill.
  assign miss = (state == idle) && !lookup_hit && !redirect_valid;

  // Between leaving idle and reaching write-back.
  assign refill_busy = (state != idle) && (state != write_back);

  // #########################################################################
  // Memory read port
  // #########################################################################

  assign line_tag   = line_addr[index_w +: tag_w];
  assign line_index = line_addr[index_w-1:0];
  assign req_offset = (state == req_1) ? offset_w'(1) : offset_w'(0);

  assign mem_arvalid = (state == req_0) || (state == req_1);
  assign mem_araddr  = {line_addr, req_offset, 2'b00};
  assign mem_rready  = (state == resp_0) || (state == resp_1);

  // #########################################################################
  // Refill FSM
  // #########################################################################

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= idle;
      line_valid    <= '0;
      pend_redirect <= 1'b0;
      pend_fence    <= 1'b0;
    end else begin
      if (redirect_valid && refill_busy) begin
        pend_redirect <= 1'b1;
      end
      if (fence && refill_busy) begin
        pend_fence <= 1'b1; // The clear is applied at write-back.
      end

      unique case (state)
        idle: begin
          if (fence) begin
            line_valid <= '0;
          end else if (miss) begin
            state <= req_0;
          end
        end
        req_0: begin
          if (mem_arready) begin
            state <= resp_0;
          end
        end
        resp_0: begin
          if (mem_rvalid) begin
            state <= req_1;
          end
        end
        req_1: begin
          if (mem_arready) begin
            state <= resp_1;
          end
        end
        resp_1: begin
          if (mem_rvalid) begin
            state                  <= write_back;
            line_valid[line_index] <= 1'b1;
          end
        end
        write_back: begin
          state         <= idle;
          pend_redirect <= 1'b0;
          if (pend_fence || fence) begin
            line_valid <= '0; // This also drops the line just filled.
            pend_fence <= 1'b0;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // The refilled line is captured at the miss and written word by word.
  always_ff @(posedge clock) begin
    if (miss) begin
      line_addr <= fetch_pc[xlen-1 : offset_w+2];
    end
    if ((state == resp_0) && mem_rvalid) begin
      data_mem[line_index][0] <= mem_rdata;
    end
    if ((state == resp_1) && mem_rvalid) begin
      data_mem[line_index][1] <= mem_rdata;
      tag_mem[line_index]     <= line_tag;
    end
  end

  // #########################################################################
  // Checks
  // #########################################################################

  // A pending address request holds until the memory accepts it.
  assert property (@(posedge clock) disable iff (reset)
    (mem_arvalid && !mem_arready) |=> (mem_arvalid && $stable(mem_araddr)));

  // Responses come back only while a response is being waited for.
  assert property (@(posedge clock) disable iff (reset)
    mem_rvalid |-> (state inside {resp_0, resp_1}));

endmodule

// ==== hw/fetch_inst_queue.sv ====
module fetch_inst_queue (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      push,
  input  logic [fetch_pkg::xlen-1:0] push_pc,
  input  logic [fetch_pkg::xlen-1:0] push_inst,
  output logic                      queue_ready,
  input  logic                      flush,
  output logic                      inst_valid,
  input  logic                      inst_ready,
  output logic [fetch_pkg::xlen-1:0] inst_pc,
  output logic [fetch_pkg::xlen-1:0] inst_data
);

  import fetch_pkg::*;

  localparam logic [queue_ptr_w:0] full_count = (queue_ptr_w + 1)'(queue_depth);

  logic [xlen-1:0] pc_mem   [queue_depth];
  logic [xlen-1:0] inst_mem [queue_depth];

  logic [queue_ptr_w-1:0] rd_ptr;
  logic [queue_ptr_w-1:0] wr_ptr;
  logic [queue_ptr_w:0]   count;

  logic do_push;
  logic do_pop;

  assign queue_ready = (count != full_count);
  assign inst_valid  = (count != '0) && !flush; // A flushed entry is never handed out.
  assign inst_pc     = pc_mem[rd_ptr];
  assign inst_data   = inst_mem[rd_ptr];

  assign do_push = push && !flush;
  assign do_pop  = inst_valid && inst_ready;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      pc_mem[wr_ptr]   <= push_pc;
      inst_mem[wr_ptr] <= push_inst;
    end
  end

  // The sequencer only pushes when the queue has room.
  assert property (@(posedge clock) disable iff (reset)
    push |-> (count != full_count));

endmodule

// ==== hw/fetch_unit.sv ====
module fetch_unit (
  input  logic                      clock,
  input  logic                      reset,

  // Decoder side.
  input  logic                      redirect_valid,
  input  logic [fetch_pkg::xlen-1:0] redirect_pc,
  input  logic                      fence,
  output logic                      inst_valid,
  input  logic                      inst_ready,
  output logic [fetch_pkg::xlen-1:0] inst_pc,
  output logic [fetch_pkg::xlen-1:0] inst_data,

  // Memory read port.
  output logic                      mem_arvalid,
  output logic [fetch_pkg::xlen-1:0] mem_araddr,
  input  logic                      mem_arready,
  input  logic                      mem_rvalid,
  input  logic [fetch_pkg::xlen-1:0] mem_rdata,
  output logic                      mem_rready
);

  import fetch_pkg::*;

  logic [xlen-1:0] fetch_pc;
  logic            hit_valid;
  logic [xlen-1:0] hit_inst;
  logic            queue_ready;

  // A hit that finds room in the queue is pushed and moves the PC on.
  wire queue_push = hit_valid && queue_ready;

  fetch_pc fetch_pc_i (
    .clock          (clock),
    .reset          (reset),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .hit_valid      (hit_valid),
    .queue_ready    (queue_ready),
    .fetch_pc       (fetch_pc)
  );

  fetch_l1i fetch_l1i_i (
    .clock          (clock),
    .reset          (reset),
    .fetch_pc       (fetch_pc),
    .redirect_valid (redirect_valid),
    .fence          (fence),
    .hit_valid      (hit_valid),
    .hit_inst       (hit_inst),
    .mem_arvalid    (mem_arvalid),
    .mem_araddr     (mem_araddr),
    .mem_arready    (mem_arready),
    .mem_rvalid     (mem_rvalid),
    .mem_rdata      (mem_rdata),
    .mem_rready     (mem_rready)
  );

  fetch_inst_queue fetch_inst_queue_i (
    .clock       (clock),
    .reset       (reset),
    .push        (queue_push),
    .push_pc     (fetch_pc),
    .push_inst   (hit_inst),
    .queue_ready (queue_ready),
    .flush       (redirect_valid),
    .inst_valid  (inst_valid),
    .inst_ready  (inst_ready),
    .inst_pc     (inst_pc),
    .inst_data   (inst_data)
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clock = 1'b0,
  output logic reset = 1'b1
);

  localparam int half_period  = 5;
  localparam int reset_cycles = 8;

  initial begin
    forever #half_period clock = ~clock;
  end

  // Reset drops on a falling edge, like every other input of the DUT.
  initial begin
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

// ==== verif/tb_fetch_mem.sv ====
module tb_fetch_mem (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [31:0]                rand_word,
  input  logic                       gen_bump,
  input  logic                       mem_arvalid,
  input  logic [fetch_pkg::xlen-1:0] mem_araddr,
  output logic                       mem_arready = 1'b0,
  output logic                       mem_rvalid = 1'b0,
  output logic [fetch_pkg::xlen-1:0] mem_rdata = '0,
  input  logic                       mem_rready
);

  import fetch_pkg::*;

  logic [31:0]     generation;
  logic            busy;       // An address is accepted and its response is still owed.
  logic [2:0]      delay;      // Cycles left before the response shows up.
  logic [xlen-1:0] resp_addr;
  logic [31:0]     resp_gen;
  logic            ready_roll;

  // Memory contents as a mix of the word address and the generation.
  function automatic logic [xlen-1:0] word_at(input logic [xlen-1:0] addr,
                                             input logic [31:0] gen);
    logic [31:0] x;
    x = addr ^ (gen * 32'h9E37_79B9);
    x = x ^ (x >> 15);
    x = x * 32'h85EB_CA6B;
    x = x ^ (x >> 13);
    return x;
  endfunction

  always @(posedge clock) begin
    if (reset) begin
      generation <= '0;
      busy       <= 1'b0;
      delay      <= '0;
      resp_addr  <= '0;
      resp_gen   <= '0;
      ready_roll <= 1'b0;
    end else begin
      ready_roll <= (rand_word[5:4] != 2'd0);
      if (gen_bump) begin
        generation <= generation + 32'd1;
      end
      if (mem_arvalid && mem_arready) begin
        busy      <= 1'b1;
        resp_addr <= mem_araddr;
        resp_gen  <= generation; // Contents as of acceptance.
        delay     <= 3'(rand_word[10:8] % 6);
      end else if (busy && (delay != 3'd0)) begin
        delay <= delay - 3'd1;
      end
      if (mem_rvalid && mem_rready) begin
        busy <= 1'b0;
      end
    end
  end

  always @(negedge clock) begin
    if (reset) begin
      mem_arready <= 1'b0;
      mem_rvalid  <= 1'b0;
      mem_rdata   <= '0;
    end else begin
      mem_arready <= !busy && ready_roll;
      mem_rvalid  <= busy && (delay == 3'd0);
      mem_rdata   <= word_at(resp_addr, resp_gen);
    end
  end

endmodule

// ==== verif/tb_fetch_unit.sv ====
module tb_fetch_unit;

  import fetch_pkg::*;

  localparam int transfer_goal = 3000;
  localparam int refill_worst  = 20;
  localparam int cycle_limit   = transfer_goal * refill_worst;

  logic            clock;
  logic            reset;
  logic            redirect_valid;
  logic [xlen-1:0] redirect_pc;
  logic            fence;
  logic            inst_valid;
  logic            inst_ready;
  logic [xlen-1:0] inst_pc;
  logic [xlen-1:0] inst_data;
  logic            mem_arvalid;
  logic [xlen-1:0] mem_araddr;
  logic            mem_arready;
  logic            mem_rvalid;
  logic [xlen-1:0] mem_rdata;
  logic            mem_rready;
  logic [31:0]     rand_word;
  logic            gen_bump;

  logic [31:0]     lcg_state = 32'd61;
  logic [xlen-1:0] model_pc;
  logic [31:0]     model_gen;
  int              transfers;
  int              cycle_count;

  tb_clock_gen clock_gen_i (.clock(clock), .reset(reset));

  tb_fetch_mem mem_i (
    .clock       (clock),
    .reset       (reset),
    .rand_word   (rand_word),
    .gen_bump    (gen_bump),
    .mem_arvalid (mem_arvalid),
    .mem_araddr  (mem_araddr),
    .mem_arready (mem_arready),
    .mem_rvalid  (mem_rvalid),
    .mem_rdata   (mem_rdata),
    .mem_rready  (mem_rready)
  );

  fetch_unit fetch_unit_i (
    .clock          (clock),
    .reset          (reset),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .fence          (fence),
    .inst_valid     (inst_valid),
    .inst_ready     (inst_ready),
    .inst_pc        (inst_pc),
    .inst_data      (inst_data),
    .mem_arvalid    (mem_arvalid),
    .mem_araddr     (mem_araddr),
    .mem_arready    (mem_arready),
    .mem_rvalid     (mem_rvalid),
    .mem_rdata      (mem_rdata),
    .mem_rready     (mem_rready)
  );

  // ##########################################################################
  // Helpers
  // ##########################################################################

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 16); // Folds the better high bits down.
  endfunction

  // Word the memory holds at an address in a given generation.
  function automatic logic [xlen-1:0] expected_word(input logic [xlen-1:0] addr,
                                                   input logic [31:0] gen);
    logic [31:0] x;
    x = addr ^ (gen * 32'h9E37_79B9);
    x = x ^ (x >> 15);
    x = x * 32'h85EB_CA6B;
    x = x ^ (x >> 13);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] seen,
                             input logic [31:0] expected);
    if (seen !== expected) begin
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, seen, expected);
      $display("TB FAILED");
      $fatal(1, "Stopped at the first error.");
    end
  endtask

  // ##########################################################################
  // Stimulus and reference model
  // ##########################################################################

  initial begin : stimulus
    logic [31:0]     roll;
    int              stall_left;
    logic            held_valid;
    logic [xlen-1:0] held_pc;
    logic [xlen-1:0] held_data;
    logic            second_word;
    logic [xlen-1:0] word0_addr;

    redirect_valid = 1'b0;
    redirect_pc    = '0;
    fence          = 1'b0;
    inst_ready     = 1'b0;
    rand_word      = '0;
    gen_bump       = 1'b0;
    model_pc       = reset_pc;
    model_gen      = '0;
    transfers      = 0;
    stall_left     = 0;
    held_valid     = 1'b0;
    held_pc        = '0;
    held_data      = '0;
    second_word    = 1'b0;
    word0_addr     = '0;

    while (reset !== 1'b0) @(posedge clock);
    check_value("inst_valid", inst_valid, 0); // First cycle out of reset.
    check_value("mem_arvalid", mem_arvalid, 0);
    check_value("mem_rready", mem_rready, 0);

    while (transfers < transfer_goal) begin
      @(negedge clock);
      rand_word      = lcg_next();
      roll           = lcg_next();
      redirect_valid = 1'b0;
      fence          = 1'b0;
      gen_bump       = 1'b0;
      if (stall_left > 0) begin
        inst_ready = 1'b0;
        stall_left = stall_left - 1;
      end else if (roll[24:19] == 6'd0) begin
        inst_ready = 1'b0; // A long stall lets the queue fill up.
        stall_left = 8 + int'(roll[3:0]);
      end else begin
        inst_ready = (roll[18:17] != 2'd0);
      end
      if (roll[31:27] == 5'd0) begin
        redirect_valid = 1'b1;
        redirect_pc    = reset_pc + {24'd0, roll[15:10], 2'b00};
        if (roll[26:25] == 2'd0) begin
          fence    = 1'b1;
          gen_bump = 1'b1;
        end
      end

      @(posedge clock);
      // A refill asks for word 0 of a line, then for word 1 of the same line.
      if (mem_arvalid && mem_arready) begin
        if (second_word) begin
          check_value("mem_araddr", mem_araddr, word0_addr + 32'd4);
        end else begin
          check_value("mem_araddr[2:0]", mem_araddr[2:0], 0);
        end
        word0_addr  = mem_araddr;
        second_word = !second_word;
      end
      if (held_valid && !redirect_valid) begin
        check_value("inst_valid", inst_valid, 1);
        check_value("inst_pc", inst_pc, held_pc);
        check_value("inst_data", inst_data, held_data);
      end
      if (redirect_valid) begin
        check_value("inst_valid", inst_valid, 0);
        model_pc = redirect_pc;
        if (fence) begin
          model_gen = model_gen + 32'd1;
        end
      end else if (inst_valid) begin
        check_value("inst_pc", inst_pc, model_pc);
        check_value("inst_data", inst_data, expected_word(model_pc, model_gen));
        if (inst_ready) begin
          model_pc  = model_pc + 32'd4;
          transfers = transfers + 1;
        end
      end
      held_valid = inst_valid && !inst_ready;
      held_pc    = inst_pc;
      held_data  = inst_data;
    end

    $display("TB PASSED");
    $finish;
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count = cycle_count + 1;
    end
    $display("Timeout: only %0d transfers after %0d clock cycles.", transfers, cycle_count);
    $display("TB FAILED");
    $fatal(1, "The fetch unit made too little progress.");
  end

endmodule

// ==== fetch_cache.f ====
hw/fetch_pkg.sv
hw/fetch_pc.sv
hw/fetch_l1i.sv
hw/fetch_inst_queue.sv
hw/fetch_unit.sv
verif/tb_clock_gen.sv
verif/tb_fetch_mem.sv
verif/tb_fetch_unit.sv
